//--- all.f
+incdir+design
design/sccb_pkg.sv
design/sccb_clk_gen.sv
design/sccb_master.sv
design/sccb_config_seq.sv
design/sccb_cam_config.sv
testbench/sccb_slave_model.sv
testbench/tb_sccb_cam_config.sv

//--- Bender.yml
package:
  name: sccb_cam_config

sources:
  - include_dirs:
      - design
    files:
      - design/sccb_pkg.sv
      - design/sccb_clk_gen.sv
      - design/sccb_master.sv
      - design/sccb_config_seq.sv
      - design/sccb_cam_config.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - testbench/sccb_slave_model.sv
      - testbench/tb_sccb_cam_config.sv

//--- testbench/tb_sccb_cam_config.sv
// testbench for the SCCB camera configuration subsystem, runs fault cases against a camera model
`timescale 1ns/1ps
`default_nettype none
`include "sccb_config.svh"

module tb_sccb_cam_config;

    localparam int NUM_ROWS   = 3;
    localparam int SEQ_CYCLES = 5 * 50 * 2 * `SCCB_HALF_PERIOD;  // 5 transactions of 50 periods
    localparam int MAX_CYCLES = 4 * SEQ_CYCLES * NUM_ROWS;

    typedef struct packed {
        logic       nack_on_id;
        logic       corrupt_id;
        logic       exp_done;
        logic       exp_error;
        logic [7:0] exp_writes;
    } test_row_t;

    logic      pclk;
    logic      presetn;
    logic      start;
    logic      nack_on_id;
    logic      corrupt_id;
    logic      busy;
    logic      done;
    logic      error;
    logic      sio_c;
    wire       sio_d;
    test_row_t rows [NUM_ROWS];
    int        n_checks;
    int        n_errors;
    int        cycle_count;

    pullup (sio_d);

    sccb_cam_config dut0 (
        .pclk    (pclk),
        .presetn (presetn),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .error   (error),
        .sio_c   (sio_c),
        .sio_d   (sio_d)
    );

    sccb_slave_model slave0 (
        .rst_n      (presetn),
        .nack_on_id (nack_on_id),
        .corrupt_id (corrupt_id),
        .sio_c      (sio_c),
        .sio_d      (sio_d)
    );

    always #5 pclk = ~pclk;

    always @(posedge pclk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT never raised done or error", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        begin
            n_checks++;
            if (actual !== expected) begin
                n_errors++;
                $display("Fail %0t: %s, got %h, expected %h", $time, what, actual, expected);
            end
        end
    endtask

    task automatic apply_reset();
        begin
            @(posedge pclk);
            #1;
            presetn = 1'b0;
            repeat (5) @(posedge pclk);
            #1;
            presetn = 1'b1;
            @(posedge pclk);
            #1;
            check_value(busy, 1'b0, "busy after reset");
            check_value(done, 1'b0, "done after reset");
            check_value(error, 1'b0, "error after reset");
            check_value(sio_c, 1'b1, "sio_c after reset");
            check_value(sio_d, 1'b1, "sio_d released after reset");
        end
    endtask

    task automatic run_row(input int r);
        int   gap;
        int   cycles;
        logic land;
        begin
            nack_on_id = rows[r].nack_on_id;
            corrupt_id = rows[r].corrupt_id;
            land       = (rows[r].exp_writes != 0);
            apply_reset();
            gap = $urandom_range(16, 1);
            repeat (gap) @(posedge pclk);
            #1;
            start = 1'b1;
            @(posedge pclk);
            #1;
            start  = 1'b0;
            cycles = 0;
            while (!(done || error)) begin
                check_value(busy, 1'b1, "busy while the sequence runs");
                start = (cycles == 40);  // second start while busy
                @(posedge pclk);
                #1;
                cycles++;
            end
            start = 1'b0;
            check_value(busy, 1'b0, "busy once finished");
            check_value(done, rows[r].exp_done, "done");
            check_value(error, rows[r].exp_error, "error");
            repeat (3) @(posedge pclk);
            #1;
            check_value(done, rows[r].exp_done, "done stays set");
            check_value(error, rows[r].exp_error, "error stays set");
            check_value(slave0.write_count, rows[r].exp_writes, "slave write count");
            check_value(slave0.regs[8'hFF], 8'h00, "register FF");
            check_value(slave0.regs[8'h12], land ? 8'h80 : 8'h00, "register 12");
            check_value(slave0.regs[8'h2C], land ? 8'hFF : 8'h00, "register 2C");
            check_value(slave0.regs[8'hF7], 8'h60, "register F7");
        end
    endtask

    initial begin
        pclk        = 1'b0;
        presetn     = 1'b0;
        start       = 1'b0;
        nack_on_id  = 1'b0;
        corrupt_id  = 1'b0;
        n_checks    = 0;
        n_errors    = 0;
        cycle_count = 0;
        void'($urandom(32'h7cf766be));
        // nack_on_id, corrupt_id, done, error, writes
        rows[0] = {1'b0, 1'b0, 1'b1, 1'b0, 8'(`CFG_LEN)};
        rows[1] = {1'b0, 1'b1, 1'b0, 1'b1, 8'(`CFG_LEN)};
        rows[2] = {1'b1, 1'b0, 1'b0, 1'b1, 8'd0};
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/sccb_slave_model.sv
// SCCB camera model, acknowledges its IDs, stores register writes and answers one-byte reads
`timescale 1ns/1ps
`default_nettype none
`include "sccb_config.svh"

module sccb_slave_model (
    input  logic rst_n,
    input  logic nack_on_id,   // leave every ID unanswered
    input  logic corrupt_id,   // answer 0x5A at the ID register
    input  logic sio_c,
    inout  wire  sio_d
);

    logic [7:0] regs [256];
    logic [7:0] shreg;         // incoming byte, MSB first
    logic [7:0] reg_ptr;
    logic [7:0] rd_byte;
    logic [3:0] bit_cnt;       // 8 means the ninth bit is next
    int         byte_num;      // bytes since the last start
    int         write_count;
    logic       active;
    logic       rd_mode;
    logic       rd_next;       // read ID accepted, data follows
    logic       drive_low;

    assign sio_d = drive_low ? 1'b0 : 1'bz;

    task automatic clear_state();
        begin
            for (int i = 0; i < 256; i++) begin
                regs[i] = 8'h00;
            end
            regs[`SCCB_ID_REG] = `SCCB_ID_EXPECT;
            write_count = 0;
            active      = 1'b0;
            rd_mode     = 1'b0;
            rd_next     = 1'b0;
            drive_low   = 1'b0;
            bit_cnt     = '0;
            byte_num    = 0;
            reg_ptr     = '0;
        end
    endtask

    // byte complete, decide on the acknowledge
    task automatic take_byte();
        logic ack;
        begin
            ack = 1'b1;
            case (byte_num)
                0: begin
                    ack     = !nack_on_id && (shreg == `SCCB_WR_ID || shreg == `SCCB_RD_ID);
                    rd_next = (shreg == `SCCB_RD_ID);
                end
                1: reg_ptr = shreg;
                default: begin
                    regs[reg_ptr] = shreg;
                    write_count++;
                end
            endcase
            byte_num++;
            drive_low = ack;
            if (!ack) begin
                active = 1'b0;  // ignore the bus until the next start
            end
        end
    endtask

    initial clear_state();

    always @(negedge rst_n) begin
        clear_state();
    end

    // start or repeated start
    always @(negedge sio_d) begin
        if (rst_n && sio_c === 1'b1) begin
            active    = 1'b1;
            bit_cnt   = '0;
            byte_num  = 0;
            rd_mode   = 1'b0;
            rd_next   = 1'b0;
            drive_low = 1'b0;
        end
    end

    // stop
    always @(posedge sio_d) begin
        if (sio_c === 1'b1) begin
            active    = 1'b0;
            drive_low = 1'b0;
        end
    end

    always @(posedge sio_c) begin
        if (active) begin
            if (bit_cnt == 4'd8) begin
                bit_cnt = '0;  // ninth bit
            end else begin
                if (!rd_mode) begin
                    shreg = {shreg[6:0], sio_d};
                end
                bit_cnt = bit_cnt + 1'b1;
            end
        end
    end

    always @(negedge sio_c) begin
        if (active) begin
            if (bit_cnt == 4'd8) begin
                if (rd_mode) begin
                    drive_low = 1'b0;  // master answers the read byte
                    rd_next   = 1'b0;
                end else begin
                    take_byte();
                end
            end else if (bit_cnt == 4'd0) begin
                rd_mode   = rd_next;
                rd_byte   = (corrupt_id && reg_ptr == `SCCB_ID_REG) ? 8'h5A : regs[reg_ptr];
                drive_low = rd_mode && !rd_byte[7];
            end else begin
                drive_low = rd_mode && !rd_byte[7 - bit_cnt];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/sccb_cam_config.sv
// SCCB camera configuration top, joins clock generator, bus master and sequencer
`timescale 1ns/1ps
`default_nettype none

module sccb_cam_config (
    input  logic pclk,
    input  logic presetn,
    input  logic start,
    output logic busy,
    output logic done,
    output logic error,
    output logic sio_c,
    inout  wire  sio_d
);

    logic                 scl_phase;
    logic                 mid_low;    // bit change strobe
    sccb_pkg::sccb_req_t  req;
    logic                 req_valid;
    logic                 txn_busy;
    logic                 txn_done;
    logic                 nack;
    sccb_pkg::sccb_byte_t rd_data;

    sccb_clk_gen u_clk_gen (
        .pclk      (pclk),
        .presetn   (presetn),
        .scl_phase (scl_phase),
        .mid_low   (mid_low)
    );

    sccb_master u_master (
        .pclk      (pclk),
        .presetn   (presetn),
        .scl_phase (scl_phase),
        .mid_low   (mid_low),
        .req       (req),
        .req_valid (req_valid),
        .txn_busy  (txn_busy),
        .txn_done  (txn_done),
        .nack      (nack),
        .rd_data   (rd_data),
        .sio_c     (sio_c),
        .sio_d     (sio_d)
    );

    sccb_config_seq u_seq (
        .pclk      (pclk),
        .presetn   (presetn),
        .start     (start),
        .txn_busy  (txn_busy),
        .txn_done  (txn_done),
        .nack      (nack),
        .rd_data   (rd_data),
        .req       (req),
        .req_valid (req_valid),
        .busy      (busy),
        .done      (done),
        .error     (error)
    );

endmodule

`default_nettype wire

//--- design/sccb_config_seq.sv
// SCCB configuration sequencer, writes the register table then checks the sensor ID
`timescale 1ns/1ps
`default_nettype none
`include "sccb_config.svh"

module sccb_config_seq (
    input  logic                 pclk,
    input  logic                 presetn,
    input  logic                 start,
    input  logic                 txn_busy,
    input  logic                 txn_done,
    input  logic                 nack,
    input  sccb_pkg::sccb_byte_t rd_data,
    output sccb_pkg::sccb_req_t  req,
    output logic                 req_valid,
    output logic                 busy,
    output logic                 done,
    output logic                 error
);

    localparam int IW = $clog2(`CFG_LEN);

    // {address, data} pairs in issue order
    localparam logic [15:0] CFG_ROM [`CFG_LEN] = '{
        `CFG_ENTRY_0,
        `CFG_ENTRY_1,
        `CFG_ENTRY_2,
        `CFG_ENTRY_3
    };

    sccb_pkg::cfg_state_t state;
    logic [IW-1:0]        idx;    // current table entry
    logic                 id_ok;  // outcome of the run

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            state     <= sccb_pkg::CFG_IDLE;
            idx       <= '0;
            id_ok     <= 1'b0;
            req       <= '0;
            req_valid <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            error     <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            case (state)
                sccb_pkg::CFG_IDLE: begin
                    if (start) begin
                        busy  <= 1'b1;
                        done  <= 1'b0;  // sticky flags clear on a new run
                        error <= 1'b0;
                        idx   <= '0;
                        state <= sccb_pkg::CFG_ISSUE;
                    end
                end
                sccb_pkg::CFG_ISSUE: begin
                    if (!txn_busy) begin
                        req_valid <= 1'b1;
                        req       <= '{rd: 1'b0, addr: CFG_ROM[idx][15:8], data: CFG_ROM[idx][7:0]};
                        state     <= sccb_pkg::CFG_WAIT_WR;
                    end
                end
                sccb_pkg::CFG_WAIT_WR: begin
                    if (txn_done) begin
                        if (nack) begin
                            id_ok <= 1'b0;  // abandon the table
                            state <= sccb_pkg::CFG_FINISH;
                        end else if (idx == IW'(`CFG_LEN - 1)) begin
                            state <= sccb_pkg::CFG_ISSUE_RD;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= sccb_pkg::CFG_ISSUE;
                        end
                    end
                end
                sccb_pkg::CFG_ISSUE_RD: begin
                    if (!txn_busy) begin
                        req_valid <= 1'b1;
                        req       <= '{rd: 1'b1, addr: `SCCB_ID_REG, data: 8'h00};
                        state     <= sccb_pkg::CFG_WAIT_RD;
                    end
                end
                sccb_pkg::CFG_WAIT_RD: begin
                    if (txn_done) begin
                        id_ok <= !nack && (rd_data == `SCCB_ID_EXPECT);
                        state <= sccb_pkg::CFG_FINISH;
                    end
                end
                sccb_pkg::CFG_FINISH: begin
                    busy  <= 1'b0;
                    done  <= id_ok;
                    error <= !id_ok;
                    state <= sccb_pkg::CFG_IDLE;
                end
                default: state <= sccb_pkg::CFG_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/sccb_master.sv
// SCCB bus master, runs one 3-phase write or one write-then-read transaction per request
`timescale 1ns/1ps
`default_nettype none
`include "sccb_config.svh"

module sccb_master (
    input  logic                 pclk,
    input  logic                 presetn,
    input  logic                 scl_phase,
    input  logic                 mid_low,
    input  sccb_pkg::sccb_req_t  req,
    input  logic                 req_valid,
    output logic                 txn_busy,
    output logic                 txn_done,
    output logic                 nack,
    output sccb_pkg::sccb_byte_t rd_data,
    output logic                 sio_c,
    inout  wire                  sio_d
);

    sccb_pkg::sccb_phase_t state;
    sccb_pkg::sccb_req_t   req_q;      // request held for the whole transaction
    sccb_pkg::sccb_byte_t  tx_sh;      // outgoing bits, MSB first
    sccb_pkg::sccb_byte_t  rx_sh;      // read data shifted in
    sccb_pkg::sccb_byte_t  next_byte;
    logic [2:0]            bit_cnt;
    logic [1:0]            byte_idx;   // 0 id, 1 addr, 2 data or read id, 3 read data
    logic                  armed;      // start condition already on the bus
    logic                  clk_en;     // sio_c follows scl_phase
    logic                  sda_lo;     // pull sio_d low
    logic                  nack_q;
    logic                  scl_d;
    logic                  scl_rise;
    logic                  rx_byte;

    assign txn_busy = (state != sccb_pkg::PH_IDLE);
    assign sio_c    = scl_phase | ~clk_en;
    assign sio_d    = sda_lo ? 1'b0 : 1'bz;  // open drain
    assign scl_rise = scl_phase & ~scl_d;
    assign rx_byte  = req_q.rd && (byte_idx == 2'd3);

    always_comb begin
        case (byte_idx)
            2'd0:    next_byte = req_q.addr;
            2'd1:    next_byte = req_q.data;
            default: next_byte = 8'hFF;  // all ones keeps sio_d released for read data
        endcase
    end

    always_ff @(posedge pclk) begin
        if (state == sccb_pkg::PH_IDLE && req_valid)
            req_q <= req;
        if (mid_low && state == sccb_pkg::PH_STOP)
            rd_data <= rx_sh;
    end

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            state    <= sccb_pkg::PH_IDLE;
            tx_sh    <= '0;
            rx_sh    <= '0;
            bit_cnt  <= '0;
            byte_idx <= '0;
            armed    <= 1'b0;
            clk_en   <= 1'b0;
            sda_lo   <= 1'b0;
            nack_q   <= 1'b0;
            scl_d    <= 1'b0;
            txn_done <= 1'b0;
            nack     <= 1'b0;
        end else begin
            scl_d    <= scl_phase;
            txn_done <= 1'b0;

            // gate changes only in the high phase so sio_c stays clean
            if (scl_phase) begin
                if (state == sccb_pkg::PH_START && armed)
                    clk_en <= 1'b1;
                else if (state == sccb_pkg::PH_RESTART || state == sccb_pkg::PH_STOP)
                    clk_en <= 1'b0;
            end

            if (scl_rise) begin
                if (state == sccb_pkg::PH_SHIFT && rx_byte)
                    rx_sh <= {rx_sh[6:0], sio_d};
                if (state == sccb_pkg::PH_ACK && !rx_byte)
                    nack_q <= sio_d;  // high means no slave answered
            end

            if (state == sccb_pkg::PH_IDLE && req_valid) begin
                state    <= sccb_pkg::PH_START;
                tx_sh    <= `SCCB_WR_ID;
                byte_idx <= '0;
                armed    <= 1'b0;
                nack_q   <= 1'b0;
            end

            if (mid_low) begin
                case (state)
                    sccb_pkg::PH_START: begin
                        if (!armed) begin
                            sda_lo <= 1'b1;  // sio_d falls, sio_c held high
                            armed  <= 1'b1;
                        end else begin
                            sda_lo  <= ~tx_sh[7];
                            tx_sh   <= {tx_sh[6:0], 1'b1};
                            bit_cnt <= '0;
                            state   <= sccb_pkg::PH_SHIFT;
                        end
                    end
                    sccb_pkg::PH_SHIFT: begin
                        if (bit_cnt == 3'd7) begin
                            sda_lo <= 1'b0;  // ninth bit, slave ack or master nack
                            state  <= sccb_pkg::PH_ACK;
                        end else begin
                            sda_lo  <= ~tx_sh[7];
                            tx_sh   <= {tx_sh[6:0], 1'b1};
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    sccb_pkg::PH_ACK: begin
                        if (nack_q || byte_idx == 2'd3 || (!req_q.rd && byte_idx == 2'd2)) begin
                            sda_lo <= 1'b1;  // low ahead of the stop
                            state  <= sccb_pkg::PH_STOP;
                        end else if (req_q.rd && byte_idx == 2'd1) begin
                            sda_lo   <= 1'b0;  // high before the repeated start
                            tx_sh    <= `SCCB_RD_ID;
                            byte_idx <= 2'd2;
                            state    <= sccb_pkg::PH_RESTART;
                        end else begin
                            sda_lo   <= ~next_byte[7];
                            tx_sh    <= {next_byte[6:0], 1'b1};
                            bit_cnt  <= '0;
                            byte_idx <= byte_idx + 1'b1;
                            state    <= sccb_pkg::PH_SHIFT;
                        end
                    end
                    sccb_pkg::PH_RESTART: begin
                        sda_lo <= 1'b1;  // repeated start while sio_c is high
                        armed  <= 1'b1;
                        state  <= sccb_pkg::PH_START;
                    end
                    sccb_pkg::PH_STOP: begin
                        sda_lo   <= 1'b0;  // sio_d rises with sio_c high
                        nack     <= nack_q;
                        txn_done <= 1'b1;
                        state    <= sccb_pkg::PH_IDLE;
                    end
                    default: ;
                endcase
            end
        end
    end

    // the sequencer may only hand over work while the bus is free
    assert property (@(posedge pclk) disable iff (!presetn) req_valid |-> !txn_busy)
        else $error("SCCB request while a transaction is in flight");

endmodule

`default_nettype wire

//--- design/sccb_clk_gen.sv
// SCCB clock generator, divides PCLK to the bit rate and marks the middle of each low phase
`timescale 1ns/1ps
`default_nettype none
`include "sccb_config.svh"

module sccb_clk_gen (
    input  logic pclk,
    input  logic presetn,
    output logic scl_phase,
    output logic mid_low
);

    localparam int HALF = `SCCB_HALF_PERIOD;
    localparam int CW   = $clog2(HALF);

    logic [CW-1:0] cnt;  // cycles into the current half period

    always_ff @(posedge pclk or negedge presetn) begin
        if (!presetn) begin
            cnt       <= '0;
            scl_phase <= 1'b0;
            mid_low   <= 1'b0;
        end else begin
            if (cnt == CW'(HALF - 1)) begin
                cnt       <= '0;
                scl_phase <= ~scl_phase;  // next half period
            end else begin
                cnt <= cnt + 1'b1;
            end
            // registered, so the pulse shows while cnt == HALF/2
            mid_low <= !scl_phase && (cnt == CW'(HALF / 2 - 1));
        end
    end

    // bit changes must never land in the high phase
    assert property (@(posedge pclk) disable iff (!presetn) mid_low |-> !scl_phase)
        else $error("mid_low pulse during SCCB clock high phase");

endmodule

`default_nettype wire

//--- design/sccb_pkg.sv
// SCCB shared types for the camera configuration path
`default_nettype none

package sccb_pkg;

    typedef logic [7:0] sccb_byte_t;  // data byte on the bus
    typedef logic [7:0] sccb_addr_t;  // sensor register address

    // one request from the sequencer to the bus master
    typedef struct packed {
        logic       rd;    // 1 reads addr, 0 writes data to addr
        sccb_addr_t addr;
        sccb_byte_t data;  // ignored on a read
    } sccb_req_t;

    // bus master phases
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_START,
        PH_SHIFT,
        PH_ACK,
        PH_STOP,
        PH_RESTART
    } sccb_phase_t;

    // configuration sequencer states
    typedef enum logic [2:0] {
        CFG_IDLE,
        CFG_ISSUE,
        CFG_WAIT_WR,
        CFG_ISSUE_RD,
        CFG_WAIT_RD,
        CFG_FINISH
    } cfg_state_t;

endpackage

`default_nettype wire

//--- design/sccb_config.svh
// SCCB camera setup constants: bus divider, device IDs and register table
`ifndef SCCB_CONFIG_SVH
`define SCCB_CONFIG_SVH

// PCLK cycles per SCCB clock half period, 4 or more
`define SCCB_HALF_PERIOD 4

// device IDs of the sensor
`define SCCB_WR_ID 8'h60
`define SCCB_RD_ID 8'h61

// slave ID register and the value it must return
`define SCCB_ID_REG    8'hF7
`define SCCB_ID_EXPECT 8'h60

// register table, {address, data} per entry
`define CFG_LEN 4
`define CFG_ENTRY_0 16'hFF01
`define CFG_ENTRY_1 16'h1280
`define CFG_ENTRY_2 16'hFF00
`define CFG_ENTRY_3 16'h2CFF

`endif
